// File: alu_backend_pkg.sv
`default_nettype none

package alu_backend_pkg;

    // data path and tag widths
    localparam int XLEN     = 32;
    localparam int ROB_ID_W = 6;

    localparam int OPCODE_W = 6;
    localparam int IMM_W    = 12;

    // R-format, second operand from src2
    localparam logic [OPCODE_W-1:0] OP_ADD  = 6'h00;
    localparam logic [OPCODE_W-1:0] OP_SUB  = 6'h01;
    localparam logic [OPCODE_W-1:0] OP_AND  = 6'h02;
    localparam logic [OPCODE_W-1:0] OP_OR   = 6'h03;
    localparam logic [OPCODE_W-1:0] OP_XOR  = 6'h04;
    localparam logic [OPCODE_W-1:0] OP_SLT  = 6'h05; // signed compare

    // I-format, second operand from imm12
    localparam logic [OPCODE_W-1:0] OP_ADDI = 6'h10; // sign-extended imm
    localparam logic [OPCODE_W-1:0] OP_ANDI = 6'h12; // zero-extended imm
    localparam logic [OPCODE_W-1:0] OP_ORI  = 6'h13; // zero-extended imm

    // one instruction word, two views
    // opcode sits in the same bits in both, so either view can pick the format
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0] opcode; // 31:26
            logic [25:0]         unused; // src2 comes from the port
        } r;
        struct packed {
            logic [OPCODE_W-1:0] opcode; // 31:26
            logic [3:0]          pad_hi;
            logic [IMM_W-1:0]    imm12;  // 21:10
            logic [9:0]          pad_lo;
        } i;
    } alu_inst_u;

endpackage

`default_nettype wire

// File: issue_dispatch.sv
`default_nettype none

module issue_dispatch #(
    parameter int LANE_COUNT = 4
) (
    input  logic                  in_valid_i,
    input  logic [LANE_COUNT-1:0] lane_busy_i,
    output logic                  in_ready_o,
    output logic [LANE_COUNT-1:0] lane_load_o
);

    logic found; // a free lane has been picked in this scan

    // ready only looks at occupancy, never at valid
    assign in_ready_o = ~(&lane_busy_i);

    // lowest numbered free lane wins
    always_comb begin
        lane_load_o = '0;
        found       = 1'b0;
        for (int i = 0; i < LANE_COUNT; i++) begin
            if (!lane_busy_i[i] && !found) begin
                lane_load_o[i] = in_valid_i;
                found          = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: alu_lane.sv
`default_nettype none

module alu_lane (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  flush_i,
    input  logic                                  load_i,
    input  alu_backend_pkg::alu_inst_u            inst_i,
    input  logic [alu_backend_pkg::XLEN-1:0]      src1_i,
    input  logic [alu_backend_pkg::XLEN-1:0]      src2_i,
    input  logic [alu_backend_pkg::ROB_ID_W-1:0]  tag_i,
    input  logic                                  grant_i,
    output logic                                  busy_o,
    output logic [alu_backend_pkg::XLEN-1:0]      result_o,
    output logic [alu_backend_pkg::ROB_ID_W-1:0]  tag_o
);

    import alu_backend_pkg::*;

    logic                busy_q;
    alu_inst_u           inst_q;
    logic [XLEN-1:0]     src1_q;
    logic [XLEN-1:0]     src2_q;
    logic [ROB_ID_W-1:0] tag_q;

    logic [XLEN-1:0]     imm_sext;
    logic [XLEN-1:0]     imm_zext;
    logic                slt_bit;

    // occupancy, flush beats everything
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
        end else if (load_i) begin
            busy_q <= 1'b1;
        end else if (grant_i) begin
            busy_q <= 1'b0; // result leaves on the bus this edge
        end
    end

    // held entry
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            inst_q <= inst_i;
            src1_q <= src1_i;
            src2_q <= src2_i;
            tag_q  <= tag_i;
        end
    end

    // immediate only meaningful in the I view
    assign imm_sext = {{(XLEN-IMM_W){inst_q.i.imm12[IMM_W-1]}}, inst_q.i.imm12};
    assign imm_zext = {{(XLEN-IMM_W){1'b0}}, inst_q.i.imm12};
    assign slt_bit  = $signed(src1_q) < $signed(src2_q);

    always_comb begin
        case (inst_q.r.opcode)
            OP_ADD:  result_o = src1_q + src2_q;
            OP_SUB:  result_o = src1_q - src2_q;
            OP_AND:  result_o = src1_q & src2_q;
            OP_OR:   result_o = src1_q | src2_q;
            OP_XOR:  result_o = src1_q ^ src2_q;
            OP_SLT:  result_o = {{(XLEN-1){1'b0}}, slt_bit};
            OP_ADDI: result_o = src1_q + imm_sext;
            OP_ANDI: result_o = src1_q & imm_zext;
            OP_ORI:  result_o = src1_q | imm_zext;
            default: result_o = '0; // unknown opcode
        endcase
    end

    assign busy_o = busy_q;
    assign tag_o  = tag_q;

endmodule

`default_nettype wire

// File: cdb_arbiter.sv
`default_nettype none

module cdb_arbiter #(
    parameter int LANE_COUNT = 4
) (
    input  logic                                                  clk_i,
    input  logic                                                  rst_n_i,
    input  logic                                                  flush_i,
    input  logic [LANE_COUNT-1:0]                                 req_i,
    input  logic [LANE_COUNT-1:0][alu_backend_pkg::XLEN-1:0]      result_i,
    input  logic [LANE_COUNT-1:0][alu_backend_pkg::ROB_ID_W-1:0]  tag_i,
    output logic [LANE_COUNT-1:0]                                 grant_o,
    output logic                                                  cdb_valid_o,
    output logic [alu_backend_pkg::XLEN-1:0]                      cdb_data_o,
    output logic [alu_backend_pkg::ROB_ID_W-1:0]                  cdb_tag_o
);

    import alu_backend_pkg::*;

    localparam int PTR_W = $clog2(LANE_COUNT);

    logic [PTR_W-1:0]    ptr_q;     // first lane to look at
    logic [PTR_W-1:0]    ptr_next;
    logic                any_grant;
    int                  grant_idx;
    int                  cand;

    logic                valid_q;
    logic [XLEN-1:0]     data_q;
    logic [ROB_ID_W-1:0] tag_q;

    // scan from the pointer, wrapping around
    always_comb begin
        any_grant = 1'b0;
        grant_idx = 0;
        grant_o   = '0;
        for (int k = 0; k < LANE_COUNT; k++) begin
            cand = int'(ptr_q) + k;
            if (cand >= LANE_COUNT) begin
                cand = cand - LANE_COUNT;
            end
            if (req_i[cand] && !any_grant) begin
                any_grant     = 1'b1;
                grant_idx     = cand;
                grant_o[cand] = 1'b1;
            end
        end
    end

    // lane after the winner
    assign ptr_next = (grant_idx == LANE_COUNT - 1) ? '0 : PTR_W'(grant_idx + 1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= any_grant & ~flush_i; // no strobe under flush
            if (any_grant && !flush_i) begin
                ptr_q <= ptr_next;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (any_grant) begin
            data_q <= result_i[grant_idx];
            tag_q  <= tag_i[grant_idx];
        end
    end

    assign cdb_valid_o = valid_q;
    assign cdb_data_o  = data_q;
    assign cdb_tag_o   = tag_q;

endmodule

`default_nettype wire

// File: alu_backend.sv
`default_nettype none

module alu_backend #(
    parameter int LANE_COUNT = 4
) (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  flush_i,
    input  logic                                  in_valid_i,
    input  alu_backend_pkg::alu_inst_u            in_inst_i,
    input  logic [alu_backend_pkg::XLEN-1:0]      in_src1_i,
    input  logic [alu_backend_pkg::XLEN-1:0]      in_src2_i,
    input  logic [alu_backend_pkg::ROB_ID_W-1:0]  in_tag_i,
    output logic                                  in_ready_o,
    output logic                                  cdb_valid_o,
    output logic [alu_backend_pkg::XLEN-1:0]      cdb_data_o,
    output logic [alu_backend_pkg::ROB_ID_W-1:0]  cdb_tag_o
);

    import alu_backend_pkg::*;

    logic [LANE_COUNT-1:0]                lane_load;  // one-hot from dispatch
    logic [LANE_COUNT-1:0]                lane_busy;
    logic [LANE_COUNT-1:0]                lane_grant; // one-hot from arbiter
    logic [LANE_COUNT-1:0][XLEN-1:0]      lane_result;
    logic [LANE_COUNT-1:0][ROB_ID_W-1:0]  lane_tag;

    issue_dispatch #(
        .LANE_COUNT(LANE_COUNT)
    ) dispatch_inst (
        .in_valid_i(in_valid_i),
        .lane_busy_i(lane_busy),
        .in_ready_o(in_ready_o),
        .lane_load_o(lane_load)
    );

    // instruction fields fan out to every lane, load picks the one that keeps it
    for (genvar g = 0; g < LANE_COUNT; g++) begin : g_lane
        alu_lane lane_inst (
            .clk_i(clk_i),
            .rst_n_i(rst_n_i),
            .flush_i(flush_i),
            .load_i(lane_load[g]),
            .inst_i(in_inst_i),
            .src1_i(in_src1_i),
            .src2_i(in_src2_i),
            .tag_i(in_tag_i),
            .grant_i(lane_grant[g]),
            .busy_o(lane_busy[g]),
            .result_o(lane_result[g]),
            .tag_o(lane_tag[g])
        );
    end

    // busy doubles as the bus request
    cdb_arbiter #(
        .LANE_COUNT(LANE_COUNT)
    ) arbiter_inst (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .flush_i(flush_i),
        .req_i(lane_busy),
        .result_i(lane_result),
        .tag_i(lane_tag),
        .grant_o(lane_grant),
        .cdb_valid_o(cdb_valid_o),
        .cdb_data_o(cdb_data_o),
        .cdb_tag_o(cdb_tag_o)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o; // 4 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1 rst_n_o = 1'b1; // release away from the edge
    end

endmodule

`default_nettype wire

// File: alu_backend_props.sv
`default_nettype none

module alu_backend_props (
    input logic                                 clk_i,
    input logic                                 rst_n_i,
    input logic                                 flush_i,
    input logic                                 in_valid_i,
    input logic [alu_backend_pkg::ROB_ID_W-1:0] in_tag_i,
    input logic                                 in_ready_o,
    input logic                                 cdb_valid_o,
    input logic [alu_backend_pkg::ROB_ID_W-1:0] cdb_tag_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0; // read by the testbench monitor

    // idle bus and free lanes while reset is held
    a_reset_idle: assert property (@(posedge clk_i) !rst_n_i |-> !cdb_valid_o && in_ready_o)
        else begin
            fail_count++;
            $error("bus strobe or back-pressure during reset");
        end

    // and still idle on the first cycle after release
    a_reset_exit: assert property (@(posedge clk_i) !rst_n_i |=> !cdb_valid_o && in_ready_o)
        else begin
            fail_count++;
            $error("bus strobe or back-pressure right after reset");
        end

    // result needs at least one cycle in a lane
    a_no_early_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_valid_i && in_ready_o && !flush_i |=> !(cdb_valid_o && cdb_tag_o == $past(in_tag_i)))
        else begin
            fail_count++;
            $error("tag on the bus one cycle after its acceptance");
        end

    a_flush_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !cdb_valid_o)
        else begin
            fail_count++;
            $error("bus strobe on the cycle after a flush");
        end

endmodule

`default_nettype wire

// File: alu_backend_tb.sv
`default_nettype none

module alu_backend_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import alu_backend_pkg::*;

    localparam int LANE_COUNT   = 4;
    localparam int WAIT_LIMIT   = 40; // cycles for a handshake or a drain
    localparam int FINISH_LIMIT = 50; // cycles from accept to bus
    localparam int TAGS         = 1 << ROB_ID_W;

    logic                clk;
    logic                rst_n;
    logic                flush;
    logic                in_valid;
    alu_inst_u           in_inst;
    logic [XLEN-1:0]     in_src1;
    logic [XLEN-1:0]     in_src2;
    logic [ROB_ID_W-1:0] in_tag;
    logic                in_ready;
    logic                cdb_valid;
    logic [XLEN-1:0]     cdb_data;
    logic [ROB_ID_W-1:0] cdb_tag;

    logic [XLEN-1:0]     exp_data [TAGS];
    bit                  pending [TAGS];
    bit                  stale [TAGS];   // flushed, must never show up
    int                  accept_cyc [TAGS];
    int                  in_flight;
    int                  cyc;
    logic [ROB_ID_W-1:0] next_tag;
    string               test_name;
    logic [5:0]          r_ops [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, 6'h2a};
    logic [5:0]          i_ops [3] = '{OP_ADDI, OP_ANDI, OP_ORI};

    tb_clock_gen clock_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

    alu_backend dut_i (
        .clk_i(clk), .rst_n_i(rst_n), .flush_i(flush),
        .in_valid_i(in_valid), .in_inst_i(in_inst), .in_src1_i(in_src1),
        .in_src2_i(in_src2), .in_tag_i(in_tag), .in_ready_o(in_ready),
        .cdb_valid_o(cdb_valid), .cdb_data_o(cdb_data), .cdb_tag_o(cdb_tag)
    );

    bind alu_backend alu_backend_props props_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i), .in_valid_i(in_valid_i),
        .in_tag_i(in_tag_i), .in_ready_o(in_ready_o), .cdb_valid_o(cdb_valid_o),
        .cdb_tag_o(cdb_tag_o)
    );

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        $display("FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_problem(input string msg);
        $display("error in %s: %s", test_name, msg);
        stop_with_failure();
    endtask

    // reference ALU, straight from the opcode table
    function automatic logic [XLEN-1:0] model_alu(input alu_inst_u inst,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        int              simm;
        logic [XLEN-1:0] zimm;
        logic            less;
        simm = $signed(inst.i.imm12); // widened with its sign
        zimm = inst.i.imm12;
        less = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b); // signed compare
        case (inst.r.opcode)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return XLEN'(less);
            OP_ADDI: return a + XLEN'(simm);
            OP_ANDI: return a & zimm;
            OP_ORI:  return a | zimm;
            default: return '0;
        endcase
    endfunction

    task automatic check_strobe();
        assert (!stale[cdb_tag])
            else report_problem($sformatf("flushed tag %0d on the bus", cdb_tag));
        assert (pending[cdb_tag])
            else report_problem($sformatf("tag %0d not in flight", cdb_tag));
        // earliest slot is two cycles after the accept decision
        assert (cyc - accept_cyc[cdb_tag] >= 2)
            else report_problem($sformatf("tag %0d on the bus too early", cdb_tag));
        assert (cdb_data == exp_data[cdb_tag])
            else report_mismatch($sformatf("data of tag %0d", cdb_tag), exp_data[cdb_tag],
                                 cdb_data);
        pending[cdb_tag] = 1'b0;
        in_flight--;
    endtask

    // scoreboard, sampled mid-cycle where every signal is settled
    always @(negedge clk) begin
        if (rst_n) begin
            cyc++;
            assert (dut_i.props_inst.fail_count == 0)
                else report_problem("a property on the DUT ports failed");
            if (cdb_valid) check_strobe();
            assert (in_ready == (in_flight < LANE_COUNT))
                else report_mismatch("in_ready", XLEN'(in_flight < LANE_COUNT), XLEN'(in_ready));
            if (in_valid && in_ready) begin // loads on the coming edge
                pending[in_tag]    = 1'b1;
                exp_data[in_tag]   = model_alu(in_inst, in_src1, in_src2);
                accept_cyc[in_tag] = cyc;
                in_flight++;
            end
            if (flush) begin // drops even a same-cycle load
                for (int t = 0; t < TAGS; t++) begin
                    stale[t]   = stale[t] | pending[t];
                    pending[t] = 1'b0;
                end
                in_flight = 0;
            end
            for (int t = 0; t < TAGS; t++) begin
                assert (!pending[t] || cyc - accept_cyc[t] <= FINISH_LIMIT)
                    else report_problem($sformatf("tag %0d never reached the bus", t));
            end
        end
    end

    task automatic issue_one(input logic [5:0] op, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
        int waited;
        waited = 0;
        while (pending[next_tag] || stale[next_tag]) begin // skip tags still in use
            next_tag++;
            waited++;
            if (waited > TAGS) report_problem("no free tag left to issue");
        end
        in_inst          = $urandom; // random filler in the unused fields
        in_inst.r.opcode = op;
        in_src1          = a;
        in_src2          = b;
        in_tag           = next_tag;
        in_valid         = 1'b1;
        next_tag++;
        waited = 0;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) report_problem("in_ready stayed low, instruction stuck");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int waited;
        waited   = 0;
        in_valid = 1'b0;
        while (in_flight != 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) report_problem("results did not drain from the lanes");
        end
        #1;
    endtask

    initial begin
        int waited;
        void'($urandom(22));
        flush = 1'b0;
        in_valid = 1'b0;
        in_inst = '0;
        in_src1 = '0;
        in_src2 = '0;
        in_tag = '0;
        in_flight = 0;
        cyc = 0;
        next_tag = '0;
        for (int t = 0; t < TAGS; t++) begin
            pending[t] = 1'b0;
            stale[t] = 1'b0;
            accept_cyc[t] = 0;
        end
        test_name = "reset";
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) report_problem("reset was never released");
        end
        @(posedge clk);
        #1;

        test_name = "r_format";
        issue_one(OP_SLT, 32'hffff_fff0, 32'h0000_0010); // negative vs positive
        issue_one(OP_SLT, 32'h0000_0010, 32'hffff_fff0);
        repeat (40) issue_one(r_ops[$urandom_range(6)], $urandom, $urandom);
        drain();

        test_name = "i_format";
        repeat (40) issue_one(i_ops[$urandom_range(2)], $urandom, $urandom);
        drain();

        test_name = "back_pressure";
        repeat (30) issue_one($urandom_range(1) ? r_ops[$urandom_range(6)]
                                                : i_ops[$urandom_range(2)],
                              $urandom, $urandom);
        drain();

        test_name = "flush";
        repeat (3) issue_one(r_ops[$urandom_range(6)], $urandom, $urandom);
        assert (in_flight > 0) else report_problem("nothing in flight when flush was raised");
        in_valid = 1'b0;
        flush    = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        repeat (10) issue_one(i_ops[$urandom_range(2)], $urandom, $urandom);
        drain();

        if (dut_i.props_inst.fail_count != 0) begin
            report_problem("a property on the DUT ports failed");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: alu_backend.f
alu_backend_pkg.sv
issue_dispatch.sv
alu_lane.sv
cdb_arbiter.sv
alu_backend.sv
tb_clock_gen.sv
alu_backend_props.sv
alu_backend_tb.sv
